// File: source/mem_shim_macros.svh
// Sizing constants shared by the split read/write memory shim and its testbench
`ifndef MEM_SHIM_MACROS_SVH
`define MEM_SHIM_MACROS_SVH

// Word address width on both command channels
`define ADDR_WIDTH 8

// Data width in bits, always a whole number of bytes
`define DATA_WIDTH 32

// Words actually implemented by the memory
// Any address at or above this value is out of range and answers SLVERR
`define MEM_WORDS 128

// Entries in each of the read and write command queues
`define CMD_FIFO_DEPTH 8

// Commands the master may still issue after it sees waitrequest high
`define ALMFULL_THRESHOLD 2

`endif

// File: source/mem_bus_pkg.sv
// Command and response types carried on the master's read and write channels
`include "mem_shim_macros.svh"

package mem_bus_pkg;

    // Response code on both return channels, Avalon encoding
    typedef enum logic [1:0]
    {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } rsp_code_e;

    // A read command carries only the word address
    typedef struct packed
    {
        logic [`ADDR_WIDTH-1:0] addr;
    } rd_cmd_t;

    // A write command carries the address, the data and one enable per byte
    typedef struct packed
    {
        logic [`ADDR_WIDTH-1:0]   addr;
        logic [`DATA_WIDTH-1:0]   data;
        logic [`DATA_WIDTH/8-1:0] byteenable;
    } wr_cmd_t;

    // Read data comes back together with its response code
    typedef struct packed
    {
        logic [`DATA_WIDTH-1:0] data;
        rsp_code_e              rsp;
    } rd_rsp_t;

    // A write response is only the code
    typedef struct packed
    {
        rsp_code_e rsp;
    } wr_rsp_t;

endpackage

// File: source/mem_ctrl_pkg.sv
// Opcode and state encodings used inside the memory executor
package mem_ctrl_pkg;

    // Channel served by the executor, kept as the last grant for round robin
    typedef enum logic
    {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } mem_op_e;

    // Executor FSM states
    // EX_HOLD covers the stalled cycles and the recovery cycle after them
    typedef enum logic [1:0]
    {
        EX_IDLE  = 2'b00,
        EX_ISSUE = 2'b01,
        EX_HOLD  = 2'b10
    } exec_state_e;

endpackage

// File: source/mem_cmd_decode.sv
// Command decode, queues read and write commands and drives the almost-full waitrequests
`timescale 1ns/1ps
`include "mem_shim_macros.svh"

module mem_cmd_decode
(
    input  logic                 mem_master,
    input  logic                 reset,
    input  logic                 rd_read,
    input  mem_bus_pkg::rd_cmd_t rd_cmd,
    input  logic                 wr_write,
    input  mem_bus_pkg::wr_cmd_t wr_cmd,
    input  logic                 rd_pop,
    input  logic                 wr_pop,
    output logic                 rd_waitrequest,
    output logic                 wr_waitrequest,
    output logic                 rd_pending,
    output mem_bus_pkg::rd_cmd_t rd_head,
    output logic                 wr_pending,
    output mem_bus_pkg::wr_cmd_t wr_head,
    output logic                 cmd_overflow
);

    localparam int PTR_W = $clog2(`CMD_FIFO_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    // Free slots at or below which waitrequest is raised
    // One slot above the threshold covers the strobe the master had
    // already launched when it last sampled waitrequest low
    localparam int HOLD_BACK = `ALMFULL_THRESHOLD + 1;

    mem_bus_pkg::rd_cmd_t rd_q [`CMD_FIFO_DEPTH];
    mem_bus_pkg::wr_cmd_t wr_q [`CMD_FIFO_DEPTH];

    logic [PTR_W-1:0] rd_wptr, rd_rptr, wr_wptr, wr_rptr;
    logic [CNT_W-1:0] rd_count, rd_count_next, wr_count, wr_count_next;
    logic             rd_full, rd_push, wr_full, wr_push;

    // Circular pointer step, wraps for any depth
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(`CMD_FIFO_DEPTH - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    // True when the occupancy after this edge leaves too little room
    function automatic logic almost_full(input logic [CNT_W-1:0] cnt);
        return (CNT_W'(`CMD_FIFO_DEPTH) - cnt) <= CNT_W'(HOLD_BACK);
    endfunction

    // A strobe that meets a full queue is lost, never pushed
    assign rd_full = (rd_count == CNT_W'(`CMD_FIFO_DEPTH));
    assign wr_full = (wr_count == CNT_W'(`CMD_FIFO_DEPTH));
    assign rd_push = rd_read && !rd_full;
    assign wr_push = wr_write && !wr_full;

    assign rd_count_next = rd_count + CNT_W'(rd_push) - CNT_W'(rd_pop);
    assign wr_count_next = wr_count + CNT_W'(wr_push) - CNT_W'(wr_pop);

    // The head entry is visible as soon as the push edge has passed
    assign rd_pending = (rd_count != '0);
    assign wr_pending = (wr_count != '0);
    assign rd_head    = rd_q[rd_rptr];
    assign wr_head    = wr_q[wr_rptr];

    always_ff @(posedge mem_master)
    begin
        if (reset)
        begin
            rd_wptr        <= '0;
            rd_rptr        <= '0;
            rd_count       <= '0;
            wr_wptr        <= '0;
            wr_rptr        <= '0;
            wr_count       <= '0;
            // The master sees back-pressure until the first edge out of reset
            rd_waitrequest <= 1'b1;
            wr_waitrequest <= 1'b1;
            cmd_overflow   <= 1'b0;
        end
        else
        begin
            if (rd_push)
                rd_wptr <= ptr_inc(rd_wptr);
            if (rd_pop)
                rd_rptr <= ptr_inc(rd_rptr);
            if (wr_push)
                wr_wptr <= ptr_inc(wr_wptr);
            if (wr_pop)
                wr_rptr <= ptr_inc(wr_rptr);
            rd_count       <= rd_count_next;
            wr_count       <= wr_count_next;
            rd_waitrequest <= almost_full(rd_count_next);
            wr_waitrequest <= almost_full(wr_count_next);
            // Sticky until reset so a single lost command is never missed
            cmd_overflow   <= cmd_overflow || (rd_read && rd_full) || (wr_write && wr_full);
        end
    end

    // Queue storage
    always_ff @(posedge mem_master)
    begin
        if (rd_push)
            rd_q[rd_wptr] <= rd_cmd;
        if (wr_push)
            wr_q[wr_wptr] <= wr_cmd;
    end

endmodule

// File: source/mem_execute.sv
// Memory executor, arbitrates the two queues and performs one access per cycle
`timescale 1ns/1ps
`include "mem_shim_macros.svh"

module mem_execute
(
    input  logic                 mem_master,
    input  logic                 reset,
    input  logic                 mem_stall,
    input  logic                 rd_pending,
    input  mem_bus_pkg::rd_cmd_t rd_head,
    input  logic                 wr_pending,
    input  mem_bus_pkg::wr_cmd_t wr_head,
    output logic                 rd_pop,
    output logic                 wr_pop,
    output logic                 rd_done,
    output mem_bus_pkg::rd_rsp_t rd_result,
    output logic                 wr_done,
    output mem_bus_pkg::wr_rsp_t wr_result
);

    localparam int MEM_AW = $clog2(`MEM_WORDS);
    localparam int BE_W   = `DATA_WIDTH / 8;

    logic [`DATA_WIDTH-1:0] mem_array [`MEM_WORDS];

    mem_ctrl_pkg::exec_state_e ex_state, ex_state_next;
    mem_ctrl_pkg::mem_op_e     last_op;

    logic                   issue_ok;
    logic                   rd_in_range, wr_in_range;
    logic [MEM_AW-1:0]      rd_index, wr_index;
    logic [`DATA_WIDTH-1:0] wr_merged;

    // No access while the slave is busy, nor in the recovery cycle after it
    assign issue_ok = !mem_stall && (ex_state != mem_ctrl_pkg::EX_HOLD);

    // Round robin, the channel not served last wins a tie
    assign rd_pop = issue_ok && rd_pending &&
                    (!wr_pending || last_op == mem_ctrl_pkg::OP_WRITE);
    assign wr_pop = issue_ok && wr_pending &&
                    (!rd_pending || last_op == mem_ctrl_pkg::OP_READ);

    assign rd_in_range = int'(rd_head.addr) < `MEM_WORDS;
    assign wr_in_range = int'(wr_head.addr) < `MEM_WORDS;
    assign rd_index    = rd_head.addr[MEM_AW-1:0];
    assign wr_index    = wr_head.addr[MEM_AW-1:0];

    // Read-modify-write, only enabled bytes take the new data
    always_comb
    begin
        wr_merged = mem_array[wr_index];
        for (int b = 0; b < BE_W; b++)
        begin
            if (wr_head.byteenable[b])
                wr_merged[8*b +: 8] = wr_head.data[8*b +: 8];
        end
    end

    always_comb
    begin
        if (mem_stall)
            ex_state_next = mem_ctrl_pkg::EX_HOLD;
        else if (rd_pending || wr_pending)
            ex_state_next = mem_ctrl_pkg::EX_ISSUE;
        else
            ex_state_next = mem_ctrl_pkg::EX_IDLE;
    end

    always_ff @(posedge mem_master)
    begin
        if (reset)
        begin
            ex_state <= mem_ctrl_pkg::EX_IDLE;
            // Reads go first when both channels start together
            last_op  <= mem_ctrl_pkg::OP_WRITE;
            rd_done  <= 1'b0;
            wr_done  <= 1'b0;
        end
        else
        begin
            ex_state <= ex_state_next;
            if (rd_pop)
                last_op <= mem_ctrl_pkg::OP_READ;
            else if (wr_pop)
                last_op <= mem_ctrl_pkg::OP_WRITE;
            // Done pulses line up with the edge that pops the queue
            rd_done <= rd_pop;
            wr_done <= wr_pop;
        end
    end

    // Memory access and response payload
    always_ff @(posedge mem_master)
    begin
        if (rd_pop)
        begin
            rd_result.data <= rd_in_range ? mem_array[rd_index] : '0;
            rd_result.rsp  <= rd_in_range ? mem_bus_pkg::OKAY : mem_bus_pkg::SLVERR;
        end
        if (wr_pop)
        begin
            // Out of range writes leave the array untouched
            if (wr_in_range)
                mem_array[wr_index] <= wr_merged;
            wr_result.rsp <= wr_in_range ? mem_bus_pkg::OKAY : mem_bus_pkg::SLVERR;
        end
    end

endmodule

// File: source/mem_result_stage.sv
// Result stage, registers read data and write responses onto the master's return channels
`timescale 1ns/1ps

module mem_result_stage
(
    input  logic                 mem_master,
    input  logic                 reset,
    input  logic                 rd_done,
    input  mem_bus_pkg::rd_rsp_t rd_result,
    input  logic                 wr_done,
    input  mem_bus_pkg::wr_rsp_t wr_result,
    output logic                 rd_readdatavalid,
    output mem_bus_pkg::rd_rsp_t rd_rsp,
    output logic                 wr_writeresponsevalid,
    output mem_bus_pkg::wr_rsp_t wr_rsp
);

    // Valid pulses trail the executor's done pulses by one cycle
    // Reset holds them low so no stray response leaves the shim
    always_ff @(posedge mem_master)
    begin
        if (reset)
        begin
            rd_readdatavalid      <= 1'b0;
            wr_writeresponsevalid <= 1'b0;
        end
        else
        begin
            rd_readdatavalid      <= rd_done;
            wr_writeresponsevalid <= wr_done;
        end
    end

    // Payload is captured only with a completion and holds between them
    always_ff @(posedge mem_master)
    begin
        if (rd_done)
            rd_rsp <= rd_result;
        if (wr_done)
            wr_rsp <= wr_result;
    end

endmodule

// File: source/mem_rdwr_shim.sv
// Split read/write memory shim top, connecting command decode, executor and result stage
`timescale 1ns/1ps

module mem_rdwr_shim
(
    input  logic                 mem_master,
    input  logic                 reset,
    // Read channel
    input  logic                 rd_read,
    input  mem_bus_pkg::rd_cmd_t rd_cmd,
    output logic                 rd_waitrequest,
    output logic                 rd_readdatavalid,
    output mem_bus_pkg::rd_rsp_t rd_rsp,
    // Write channel
    input  logic                 wr_write,
    input  mem_bus_pkg::wr_cmd_t wr_cmd,
    output logic                 wr_waitrequest,
    output logic                 wr_writeresponsevalid,
    output mem_bus_pkg::wr_rsp_t wr_rsp,
    // Status
    input  logic                 mem_stall,
    output logic                 cmd_overflow
);

    // Queue heads towards the executor
    logic                 rd_pending, wr_pending;
    logic                 rd_pop, wr_pop;
    mem_bus_pkg::rd_cmd_t rd_head;
    mem_bus_pkg::wr_cmd_t wr_head;

    // Completions towards the result stage
    logic                 rd_done, wr_done;
    mem_bus_pkg::rd_rsp_t rd_result;
    mem_bus_pkg::wr_rsp_t wr_result;

    mem_cmd_decode u_decode
    (
        .mem_master     (mem_master),
        .reset          (reset),
        .rd_read        (rd_read),
        .rd_cmd         (rd_cmd),
        .wr_write       (wr_write),
        .wr_cmd         (wr_cmd),
        .rd_pop         (rd_pop),
        .wr_pop         (wr_pop),
        .rd_waitrequest (rd_waitrequest),
        .wr_waitrequest (wr_waitrequest),
        .rd_pending     (rd_pending),
        .rd_head        (rd_head),
        .wr_pending     (wr_pending),
        .wr_head        (wr_head),
        .cmd_overflow   (cmd_overflow)
    );

    mem_execute u_execute
    (
        .mem_master (mem_master),
        .reset      (reset),
        .mem_stall  (mem_stall),
        .rd_pending (rd_pending),
        .rd_head    (rd_head),
        .wr_pending (wr_pending),
        .wr_head    (wr_head),
        .rd_pop     (rd_pop),
        .wr_pop     (wr_pop),
        .rd_done    (rd_done),
        .rd_result  (rd_result),
        .wr_done    (wr_done),
        .wr_result  (wr_result)
    );

    mem_result_stage u_result
    (
        .mem_master            (mem_master),
        .reset                 (reset),
        .rd_done               (rd_done),
        .rd_result             (rd_result),
        .wr_done               (wr_done),
        .wr_result             (wr_result),
        .rd_readdatavalid      (rd_readdatavalid),
        .rd_rsp                (rd_rsp),
        .wr_writeresponsevalid (wr_writeresponsevalid),
        .wr_rsp                (wr_rsp)
    );

endmodule

// File: tb/mem_rdwr_shim_asserts.sv
// Protocol assertions on the command queues, bound into the command decode block
`timescale 1ns/1ps
`include "mem_shim_macros.svh"

module mem_rdwr_shim_asserts
#(
    parameter int CNT_W = $clog2(`CMD_FIFO_DEPTH) + 1
)
(
    input logic             mem_master,
    input logic             reset,
    input logic             rd_read,
    input logic             wr_write,
    input logic             rd_waitrequest,
    input logic             wr_waitrequest,
    input logic [CNT_W-1:0] rd_count,
    input logic [CNT_W-1:0] wr_count
);

    // A strobe into a full queue would be dropped
    no_rd_strobe_when_full: assert property (@(posedge mem_master) disable iff (reset)
        rd_read |-> (rd_count != CNT_W'(`CMD_FIFO_DEPTH)))
        else $error("read strobe arrived while the read queue was full");

    no_wr_strobe_when_full: assert property (@(posedge mem_master) disable iff (reset)
        wr_write |-> (wr_count != CNT_W'(`CMD_FIFO_DEPTH)))
        else $error("write strobe arrived while the write queue was full");

    // The master must see back-pressure right after a reset edge
    waitrequest_after_reset: assert property (@(posedge mem_master)
        reset |=> (rd_waitrequest && wr_waitrequest))
        else $error("waitrequest was low in the cycle after reset");

    // Occupancy is bounded by the storage
    occupancy_in_range: assert property (@(posedge mem_master) disable iff (reset)
        (rd_count <= CNT_W'(`CMD_FIFO_DEPTH)) && (wr_count <= CNT_W'(`CMD_FIFO_DEPTH)))
        else $error("queue occupancy exceeded the queue depth");

endmodule

bind mem_cmd_decode mem_rdwr_shim_asserts u_asserts
(
    .mem_master     (mem_master),
    .reset          (reset),
    .rd_read        (rd_read),
    .wr_write       (wr_write),
    .rd_waitrequest (rd_waitrequest),
    .wr_waitrequest (wr_waitrequest),
    .rd_count       (rd_count),
    .wr_count       (wr_count)
);

// File: tb/mem_rdwr_shim_tb.sv
// Testbench for the split read/write memory shim, replays a pattern file and checks responses
`timescale 1ns/1ps
`include "mem_shim_macros.svh"

module mem_rdwr_shim_tb;

    localparam int WAIT_LIMIT   = 200;
    localparam int RUN_LIMIT_NS = 200000;

    // One line of the pattern file
    typedef struct packed
    {
        int                       test;
        logic                     is_write;
        logic                     stall;
        logic [`ADDR_WIDTH-1:0]   addr;
        logic [`DATA_WIDTH-1:0]   data;
        logic [`DATA_WIDTH/8-1:0] be;
        logic [`DATA_WIDTH-1:0]   exp_data;
        mem_bus_pkg::rsp_code_e   exp_rsp;
    } step_t;

    logic                 mem_master;
    logic                 reset;
    logic                 rd_read;
    mem_bus_pkg::rd_cmd_t rd_cmd;
    logic                 rd_waitrequest;
    logic                 rd_readdatavalid;
    mem_bus_pkg::rd_rsp_t rd_rsp;
    logic                 wr_write;
    mem_bus_pkg::wr_cmd_t wr_cmd;
    logic                 wr_waitrequest;
    logic                 wr_writeresponsevalid;
    mem_bus_pkg::wr_rsp_t wr_rsp;
    logic                 mem_stall;
    logic                 cmd_overflow;

    step_t                steps[$];
    step_t                fill_list[$];
    // Expected responses per channel, oldest first
    mem_bus_pkg::rd_rsp_t rd_exp[$];
    mem_bus_pkg::wr_rsp_t wr_exp[$];
    mem_bus_pkg::rd_rsp_t rd_want;
    mem_bus_pkg::wr_rsp_t wr_want;

    int errors       = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int rd_got       = 0;
    int wr_got       = 0;

    mem_rdwr_shim u_mem_rdwr_shim
    (
        .mem_master            (mem_master),
        .reset                 (reset),
        .rd_read               (rd_read),
        .rd_cmd                (rd_cmd),
        .rd_waitrequest        (rd_waitrequest),
        .rd_readdatavalid      (rd_readdatavalid),
        .rd_rsp                (rd_rsp),
        .wr_write              (wr_write),
        .wr_cmd                (wr_cmd),
        .wr_waitrequest        (wr_waitrequest),
        .wr_writeresponsevalid (wr_writeresponsevalid),
        .wr_rsp                (wr_rsp),
        .mem_stall             (mem_stall),
        .cmd_overflow          (cmd_overflow)
    );

    initial
    begin
        mem_master = 1'b0;
        forever #20 mem_master = ~mem_master;
    end

    // Hard limit on the whole run
    initial
    begin
        #(RUN_LIMIT_NS);
        $display("simulation ran past %0d ns without finishing", RUN_LIMIT_NS);
        $display("TEST FAILED");
        $finish;
    end

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (actual !== expected)
        begin
            errors++;
            $display("mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic note_failure(input string what);
        errors++;
        $display("error at %0t: %s", $time, what);
    endtask

    task automatic end_test(input string name, input int start_errors);
        tests_run++;
        if (errors > start_errors)
            tests_failed++;
        $display("test %0d %s: %s", tests_run, name,
                 (errors > start_errors) ? "failed" : "passed");
    endtask

    // Pattern lines that are blank or start with a hash are skipped
    task automatic load_patterns();
        int          fd;
        int          n;
        int          t;
        int          op;
        int          st;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] b;
        logic [31:0] e;
        logic [31:0] r;
        string       line;
        step_t       s;
        fd = $fopen("tb/mem_patterns.txt", "r");
        if (fd == 0)
        begin
            note_failure("could not open tb/mem_patterns.txt");
            return;
        end
        while (!$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#")
                continue;
            n = $sscanf(line, "%d %d %d %h %h %h %h %h", t, op, st, a, d, b, e, r);
            if (n != 8)
            begin
                note_failure("malformed line in the pattern file");
                continue;
            end
            s.test     = t;
            s.is_write = (op != 0);
            s.stall    = (st != 0);
            s.addr     = a[`ADDR_WIDTH-1:0];
            s.data     = d;
            s.be       = b[`DATA_WIDTH/8-1:0];
            s.exp_data = e;
            s.exp_rsp  = mem_bus_pkg::rsp_code_e'(r[1:0]);
            steps.push_back(s);
        end
        $fclose(fd);
    endtask

    // Called on a rising edge, records the expected response as it drives
    task automatic drive_step(input step_t s);
        mem_bus_pkg::rd_cmd_t rc;
        mem_bus_pkg::wr_cmd_t wc;
        mem_bus_pkg::rd_rsp_t rr;
        mem_bus_pkg::wr_rsp_t wrr;
        if (s.is_write)
        begin
            wc.addr       = s.addr;
            wc.data       = s.data;
            wc.byteenable = s.be;
            wrr.rsp       = s.exp_rsp;
            wr_write <= 1'b1;
            wr_cmd   <= wc;
            wr_exp.push_back(wrr);
        end
        else
        begin
            rc.addr  = s.addr;
            rr.data  = s.exp_data;
            rr.rsp   = s.exp_rsp;
            rd_read <= 1'b1;
            rd_cmd  <= rc;
            rd_exp.push_back(rr);
        end
    endtask

    // Single command, held back while its channel shows waitrequest
    task automatic issue_step(input step_t s);
        int waited;
        waited = 0;
        @(negedge mem_master);
        while ((s.is_write ? wr_waitrequest : rd_waitrequest) && waited < WAIT_LIMIT)
        begin
            @(negedge mem_master);
            waited++;
        end
        if (waited >= WAIT_LIMIT)
            note_failure("timed out waiting for waitrequest to fall");
        @(posedge mem_master);
        drive_step(s);
        @(posedge mem_master);
        rd_read  <= 1'b0;
        wr_write <= 1'b0;
    endtask

    // Back-to-back commands until waitrequest is seen, then the allowed extra ones
    task automatic fill_channel();
        int   next;
        int   after_high;
        logic seen_high;
        next       = 0;
        after_high = 0;
        seen_high  = 1'b0;
        while (after_high < `ALMFULL_THRESHOLD)
        begin
            if (next >= fill_list.size())
            begin
                note_failure("stall patterns ran out before waitrequest rose");
                break;
            end
            @(posedge mem_master);
            drive_step(fill_list[next]);
            next++;
            if (seen_high)
                after_high++;
            @(negedge mem_master);
            if (fill_list[0].is_write ? wr_waitrequest : rd_waitrequest)
                seen_high = 1'b1;
        end
        @(posedge mem_master);
        rd_read  <= 1'b0;
        wr_write <= 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((rd_exp.size() != 0 || wr_exp.size() != 0) && waited < WAIT_LIMIT)
        begin
            @(negedge mem_master);
            waited++;
        end
        if (rd_exp.size() != 0 || wr_exp.size() != 0)
        begin
            note_failure("timed out waiting for outstanding responses");
            rd_exp.delete();
            wr_exp.delete();
        end
        // Room for any stray pulse to show up before the next test
        repeat (4) @(negedge mem_master);
    endtask

    task automatic run_reset_test();
        int start_errors;
        int waited;
        start_errors = errors;
        waited       = 0;
        @(negedge mem_master);
        compare("rd_waitrequest", 32'd1, 32'(rd_waitrequest));
        compare("wr_waitrequest", 32'd1, 32'(wr_waitrequest));
        while ((rd_waitrequest || wr_waitrequest) && waited < WAIT_LIMIT)
        begin
            @(negedge mem_master);
            waited++;
        end
        if (rd_waitrequest || wr_waitrequest)
            note_failure("waitrequest stayed high after reset");
        // Any valid pulse here is flagged by the response monitor
        repeat (8) @(negedge mem_master);
        compare("cmd_overflow", 32'd0, 32'(cmd_overflow));
        end_test("reset and idle", start_errors);
    endtask

    task automatic run_sequence(input int id, input string name, input logic gaps);
        int start_errors;
        int rd_issued;
        int wr_issued;
        int rd_before;
        int wr_before;
        start_errors = errors;
        rd_issued    = 0;
        wr_issued    = 0;
        rd_before    = rd_got;
        wr_before    = wr_got;
        foreach (steps[i])
        begin
            if (steps[i].test == id && !steps[i].stall)
            begin
                if (gaps)
                    repeat ($urandom % 4) @(posedge mem_master);
                issue_step(steps[i]);
                if (steps[i].is_write)
                    wr_issued++;
                else
                    rd_issued++;
            end
        end
        wait_drain();
        compare("read response count", 32'(rd_issued), 32'(rd_got - rd_before));
        compare("write response count", 32'(wr_issued), 32'(wr_got - wr_before));
        end_test(name, start_errors);
    endtask

    task automatic run_stall_test(input int id);
        int start_errors;
        int rd_issued;
        int wr_issued;
        int rd_before;
        int wr_before;
        start_errors = errors;
        rd_before    = rd_got;
        wr_before    = wr_got;
        @(posedge mem_master);
        mem_stall <= 1'b1;
        fill_list.delete();
        foreach (steps[i])
            if (steps[i].test == id && steps[i].stall && steps[i].is_write)
                fill_list.push_back(steps[i]);
        fill_channel();
        fill_list.delete();
        foreach (steps[i])
            if (steps[i].test == id && steps[i].stall && !steps[i].is_write)
                fill_list.push_back(steps[i]);
        fill_channel();
        rd_issued = rd_exp.size();
        wr_issued = wr_exp.size();
        repeat (4) @(posedge mem_master);
        // Nothing may complete while the memory is busy
        compare("responses under stall", 32'(rd_before + wr_before), 32'(rd_got + wr_got));
        mem_stall <= 1'b0;
        wait_drain();
        compare("cmd_overflow", 32'd0, 32'(cmd_overflow));
        compare("read response count", 32'(rd_issued), 32'(rd_got - rd_before));
        compare("write response count", 32'(wr_issued), 32'(wr_got - wr_before));
        end_test("stall and refill", start_errors);
    endtask

    // Responses are sampled half a cycle after the edge that drives them
    always @(negedge mem_master)
    begin
        if (rd_readdatavalid === 1'b1)
        begin
            rd_got++;
            if (rd_exp.size() == 0)
                note_failure("read response arrived with no read outstanding");
            else
            begin
                rd_want = rd_exp.pop_front();
                compare("rd_rsp.data", rd_want.data, rd_rsp.data);
                compare("rd_rsp.rsp", 32'(rd_want.rsp), 32'(rd_rsp.rsp));
            end
        end
        if (wr_writeresponsevalid === 1'b1)
        begin
            wr_got++;
            if (wr_exp.size() == 0)
                note_failure("write response arrived with no write outstanding");
            else
            begin
                wr_want = wr_exp.pop_front();
                compare("wr_rsp.rsp", 32'(wr_want.rsp), 32'(wr_rsp.rsp));
            end
        end
    end

    initial
    begin
        void'($urandom(32'h7c29_a1cf));
        reset     = 1'b1;
        rd_read   = 1'b0;
        rd_cmd    = '0;
        wr_write  = 1'b0;
        wr_cmd    = '0;
        mem_stall = 1'b0;
        load_patterns();
        repeat (4) @(posedge mem_master);
        reset <= 1'b0;
        run_reset_test();
        run_sequence(2, "byte enable merge", 1'b0);
        run_sequence(3, "out of range access", 1'b0);
        run_stall_test(4);
        run_sequence(5, "mixed traffic with gaps", 1'b1);
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// File: files.f
+incdir+source
source/mem_bus_pkg.sv
source/mem_ctrl_pkg.sv
source/mem_cmd_decode.sv
source/mem_execute.sv
source/mem_result_stage.sv
source/mem_rdwr_shim.sv
tb/mem_rdwr_shim_asserts.sv
tb/mem_rdwr_shim_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = mem_rdwr_shim_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^TEST OK$$"

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: tb/mem_patterns.txt
# test op(0 read, 1 write) stall addr data byteenable exp_data exp_rsp(0 OKAY, 2 SLVERR)
# Columns after stall are hex, reads ignore data and byteenable, writes ignore exp_data
2 1 0 10 11223344 f 00000000 0
2 1 0 11 a5a5a5a5 f 00000000 0
2 1 0 10 deadbeef 3 00000000 0
2 1 0 11 0f0e0d0c c 00000000 0
2 0 0 10 00000000 0 1122beef 0
2 0 0 11 00000000 0 0f0ea5a5 0
2 1 0 7f 89abcdef f 00000000 0
2 0 0 7f 00000000 0 89abcdef 0
3 1 0 80 ffffffff f 00000000 2
3 0 0 80 00000000 0 00000000 2
3 1 0 ff 12345678 f 00000000 2
3 0 0 7f 00000000 0 89abcdef 0
4 1 1 20 5a5a0020 f 00000000 0
4 1 1 21 5a5a0021 f 00000000 0
4 1 1 22 5a5a0022 f 00000000 0
4 1 1 23 5a5a0023 f 00000000 0
4 1 1 24 5a5a0024 f 00000000 0
4 1 1 25 5a5a0025 f 00000000 0
4 1 1 26 5a5a0026 f 00000000 0
4 1 1 27 5a5a0027 f 00000000 0
4 0 1 10 00000000 0 1122beef 0
4 0 1 11 00000000 0 0f0ea5a5 0
4 0 1 7f 00000000 0 89abcdef 0
4 0 1 10 00000000 0 1122beef 0
4 0 1 11 00000000 0 0f0ea5a5 0
4 0 1 7f 00000000 0 89abcdef 0
4 0 1 10 00000000 0 1122beef 0
4 0 1 11 00000000 0 0f0ea5a5 0
5 0 0 20 00000000 0 5a5a0020 0
5 1 0 30 0badf00d f 00000000 0
5 0 0 30 00000000 0 0badf00d 0
5 1 0 30 00112233 2 00000000 0
5 0 0 30 00000000 0 0bad220d 0
5 1 0 90 00000001 f 00000000 2
5 0 0 27 00000000 0 5a5a0027 0
